// File: hw/lsu_pkg.sv
/*
 * Shared widths, vector types and access-size codes for the load/store unit.
 * Modules import it inside their body and use scoped names on their ports.
 */

`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Data path widths
  ////////////////////////////////////////////////////////////

  // Byte address on the data bus
  typedef logic [31:0] addr_t;

  // Bus and register data word
  typedef logic [31:0] data_t;

  // One enable per byte lane
  typedef logic [3:0] be_t;

  // Byte position inside a word
  typedef logic [1:0] byte_offset_t;

  ////////////////////////////////////////////////////////////
  // Access size codes
  ////////////////////////////////////////////////////////////

  typedef logic [1:0] lsu_size_t;

  localparam lsu_size_t SIZE_BYTE = 2'd0;
  localparam lsu_size_t SIZE_HALF = 2'd1;
  localparam lsu_size_t SIZE_WORD = 2'd2;

  // Address step to the second word of a split access
  localparam int unsigned WORD_BYTES = 4;

endpackage

`default_nettype wire

// File: hw/lsu_req_gen.sv
/*
 * EX-stage request generation.
 * Forms the effective address, detects accesses that cross a word boundary
 * and tracks their second phase, builds byte enables and rotates store data
 * into its byte lanes. All transfer fields are combinational from the inputs.
 */

`timescale 1ns/100ps
`default_nettype none

module lsu_req_gen (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             lsu_en_i,
  input  lsu_pkg::lsu_size_t    lsu_size_i,
  input  wire logic             lsu_use_offset_i,
  input  lsu_pkg::addr_t        operand_a_i,
  input  lsu_pkg::addr_t        operand_b_i,
  input  lsu_pkg::data_t        store_data_i,
  input  wire logic             ex_done_i,
  output logic                  split_o,
  output lsu_pkg::byte_offset_t offset_o,
  output lsu_pkg::addr_t        addr_o,
  output lsu_pkg::be_t          be_o,
  output lsu_pkg::data_t        wdata_o
);

  import lsu_pkg::*;

  // High during the second transfer of a split access
  logic  second_q;
  addr_t base_addr;
  addr_t addr_int;

  ////////////////////////////////////////////////////////////
  // Effective address
  ////////////////////////////////////////////////////////////

  assign base_addr = lsu_use_offset_i ? (operand_a_i + operand_b_i) : operand_a_i;
  // Second phase steps to the next word
  assign addr_int  = base_addr + (second_q ? addr_t'(WORD_BYTES) : addr_t'(0));
  assign offset_o  = addr_int[1:0];

  // Second transfer always starts at byte lane 0
  assign addr_o = second_q ? {addr_int[31:2], 2'b00} : addr_int;

  // Word off alignment, or halfword in the top lane, needs two transfers
  always_comb
  begin
    split_o = 1'b0;
    if (lsu_en_i && !second_q)
    begin
      if (lsu_size_i == SIZE_WORD)
        split_o = (offset_o != 2'b00);
      else if (lsu_size_i == SIZE_HALF)
        split_o = (offset_o == 2'b11);
    end
  end

  // Cleared between instructions so the next one starts in phase one
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      second_q <= 1'b0;
    else if (!lsu_en_i)
      second_q <= 1'b0;
    else if (ex_done_i)
      second_q <= split_o;
  end

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (lsu_size_i)
      SIZE_BYTE: be_o = be_t'(4'b0001 << offset_o);
      SIZE_HALF:
      begin
        if (second_q)
          be_o = 4'b0001;
        else
          // Offset 3 keeps only the top lane in phase one
          be_o = be_t'(4'b0011 << offset_o);
      end
      default:
      begin
        // Phase one fills the upper lanes, phase two the rest
        if (second_q)
          be_o = be_t'(4'b1111 >> (3'd4 - {1'b0, offset_o}));
        else
          be_o = be_t'(4'b1111 << offset_o);
      end
    endcase
  end

  // Store data rotated left by the byte offset
  always_comb
  begin
    case (offset_o)
      2'b00:   wdata_o = store_data_i;
      2'b01:   wdata_o = {store_data_i[23:0], store_data_i[31:24]};
      2'b10:   wdata_o = {store_data_i[15:0], store_data_i[31:16]};
      default: wdata_o = {store_data_i[7:0], store_data_i[31:8]};
    endcase
  end

endmodule

`default_nettype wire

// File: hw/lsu_txn_ctrl.sv
/*
 * Bus transfer control.
 * Counts open transfers up to MAX_OUTSTANDING, raises the bus request and
 * decides when the EX access is complete, keeping EX and WB in lock step.
 */

`timescale 1ns/100ps
`default_nettype none

module lsu_txn_ctrl #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic lsu_en_i,
  input  wire logic split_i,
  input  wire logic data_gnt_i,
  input  wire logic data_rvalid_i,
  output logic      data_req_o,
  output logic      ready_o,
  output logic      busy_o,
  output logic      ex_done_o
);

  localparam int               CNT_W   = $clog2(MAX_OUTSTANDING + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(MAX_OUTSTANDING);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_next;
  logic             grant;
  // EX transfer granted, still waiting for WB to free up
  logic             issued_q;

  ////////////////////////////////////////////////////////////
  // Request and EX completion
  ////////////////////////////////////////////////////////////

  assign data_req_o = lsu_en_i && !issued_q && (cnt_q < CNT_MAX);
  assign grant      = data_req_o && data_gnt_i;

  always_comb
  begin
    if (!lsu_en_i)
      ex_done_o = 1'b0;
    else if (issued_q || (cnt_q == CNT_MAX))
      // Transfer already out, or no room; the older response frees WB
      ex_done_o = issued_q && data_rvalid_i;
    else if (cnt_q == '0)
      ex_done_o = grant;
    else
      ex_done_o = grant && data_rvalid_i;
  end

  // Core may only move on after the last phase
  assign ready_o = ex_done_o && !split_i;
  assign busy_o  = (cnt_q != '0) || data_req_o;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      issued_q <= 1'b0;
    else if (ex_done_o)
      issued_q <= 1'b0;
    else if (grant)
      issued_q <= 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Outstanding transfer counter
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case ({grant, data_rvalid_i})
      2'b10:   cnt_next = cnt_q + 1'b1;
      2'b01:   cnt_next = cnt_q - 1'b1;
      default: cnt_next = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_next;
  end

endmodule

`default_nettype wire

// File: hw/lsu_wb_stage.sv
/*
 * WB-side response handling.
 * Holds the control of the access in WB, aligns and extends load data,
 * merges the two halves of a split load and reports bus errors together
 * with the address of the most recent granted transfer.
 */

`timescale 1ns/100ps
`default_nettype none

module lsu_wb_stage (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             ex_done_i,
  input  wire logic             split_i,
  input  wire logic             lsu_we_i,
  input  lsu_pkg::lsu_size_t    lsu_size_i,
  input  wire logic             lsu_sign_ext_i,
  input  lsu_pkg::byte_offset_t offset_i,
  input  lsu_pkg::addr_t        addr_i,
  input  wire logic             grant_i,
  input  wire logic             data_rvalid_i,
  input  lsu_pkg::data_t        data_rdata_i,
  input  wire logic             data_err_i,
  output logic                  wb_valid_o,
  output lsu_pkg::data_t        wb_rdata_o,
  output logic                  wb_err_o,
  output lsu_pkg::addr_t        wb_addr_o
);

  import lsu_pkg::*;

  // Control of the access now in WB
  lsu_size_t    size_q;
  logic         sign_ext_q;
  logic         we_q;
  byte_offset_t offset_q;
  logic         last_q;

  // First half of a split load
  data_t        rdata_q;

  logic [7:0]   rdata_b;
  logic [15:0]  rdata_h;
  data_t        rdata_w;

  // Moves with EX so both stages stay in step
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q     <= SIZE_BYTE;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
      offset_q   <= '0;
      last_q     <= 1'b0;
    end
    else if (ex_done_i)
    begin
      size_q     <= lsu_size_i;
      sign_ext_q <= lsu_sign_ext_i;
      we_q       <= lsu_we_i;
      offset_q   <= offset_i;
      last_q     <= !split_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read data alignment
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (offset_q)
      2'b00:
      begin
        rdata_b = data_rdata_i[7:0];
        rdata_h = data_rdata_i[15:0];
        rdata_w = data_rdata_i;
      end
      2'b01:
      begin
        rdata_b = data_rdata_i[15:8];
        rdata_h = data_rdata_i[23:8];
        rdata_w = {data_rdata_i[7:0], rdata_q[31:8]};
      end
      2'b10:
      begin
        rdata_b = data_rdata_i[23:16];
        rdata_h = data_rdata_i[31:16];
        rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      end
      default:
      begin
        rdata_b = data_rdata_i[31:24];
        // Halfword across the word boundary, low byte from the carry
        rdata_h = {data_rdata_i[7:0], rdata_q[31:24]};
        rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
      end
    endcase
  end

  // Zero or sign extension by size
  always_comb
  begin
    case (size_q)
      SIZE_BYTE: wb_rdata_o = {{24{sign_ext_q && rdata_b[7]}}, rdata_b};
      SIZE_HALF: wb_rdata_o = {{16{sign_ext_q && rdata_h[15]}}, rdata_h};
      default:   wb_rdata_o = rdata_w;
    endcase
  end

  // Raw word for a first phase, final result otherwise
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !we_q)
    begin
      if (!last_q)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= wb_rdata_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Completion, errors and trap address
  ////////////////////////////////////////////////////////////

  assign wb_valid_o = last_q && data_rvalid_i;
  assign wb_err_o   = data_rvalid_i && data_err_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wb_addr_o <= '0;
    else if (grant_i)
      wb_addr_o <= addr_i;
  end

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
/*
 * Data-side load/store unit of the core.
 * Connects the EX request generator, the transfer controller and the WB
 * alignment stage to the core pipeline and to the req/gnt/rvalid data bus.
 * MAX_OUTSTANDING sets how many bus transfers may be open at once.
 */

`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  wire logic             clk,
  input  wire logic             rst_n,

  // EX stage request
  input  wire logic             lsu_en_i,
  input  wire logic             lsu_we_i,
  input  lsu_pkg::lsu_size_t    lsu_size_i,
  input  wire logic             lsu_sign_ext_i,
  input  wire logic             lsu_use_offset_i,
  input  lsu_pkg::addr_t        operand_a_i,
  input  lsu_pkg::addr_t        operand_b_i,
  input  lsu_pkg::data_t        store_data_i,
  output logic                  ready_o,
  output logic                  busy_o,

  // WB stage result
  output logic                  wb_valid_o,
  output lsu_pkg::data_t        wb_rdata_o,
  output logic                  wb_err_o,
  output lsu_pkg::addr_t        wb_addr_o,

  // Data bus
  output logic                  data_req_o,
  input  wire logic             data_gnt_i,
  output lsu_pkg::addr_t        data_addr_o,
  output logic                  data_we_o,
  output lsu_pkg::be_t          data_be_o,
  output lsu_pkg::data_t        data_wdata_o,
  input  wire logic             data_rvalid_i,
  input  lsu_pkg::data_t        data_rdata_i,
  input  wire logic             data_err_i
);

  import lsu_pkg::*;

  // EX to WB and controller
  logic         split;
  logic         ex_done;
  byte_offset_t offset;
  addr_t        addr;

  // Accepted transfer on the bus
  logic         grant;

  assign grant     = data_req_o && data_gnt_i;
  assign data_addr_o = addr;
  assign data_we_o   = lsu_we_i;

  // Address, byte enables and store data
  lsu_req_gen u_req_gen (
    .clk              (clk),
    .rst_n            (rst_n),
    .lsu_en_i         (lsu_en_i),
    .lsu_size_i       (lsu_size_i),
    .lsu_use_offset_i (lsu_use_offset_i),
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .store_data_i     (store_data_i),
    .ex_done_i        (ex_done),
    .split_o          (split),
    .offset_o         (offset),
    .addr_o           (addr),
    .be_o             (data_be_o),
    .wdata_o          (data_wdata_o)
  );

  // Outstanding count and EX handshake
  lsu_txn_ctrl #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_txn_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .lsu_en_i      (lsu_en_i),
    .split_i       (split),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .ready_o       (ready_o),
    .busy_o        (busy_o),
    .ex_done_o     (ex_done)
  );

  // Response alignment and reporting
  lsu_wb_stage u_wb_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_done_i      (ex_done),
    .split_i        (split),
    .lsu_we_i       (lsu_we_i),
    .lsu_size_i     (lsu_size_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .offset_i       (offset),
    .addr_i         (addr),
    .grant_i        (grant),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .data_err_i     (data_err_i),
    .wb_valid_o     (wb_valid_o),
    .wb_rdata_o     (wb_rdata_o),
    .wb_err_o       (wb_err_o),
    .wb_addr_o      (wb_addr_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_lsu.sv
/*
 * Testbench for the load/store unit.
 * Runs the accesses listed in dv/lsu_tests.txt back to back against a
 * behavioral bus memory with random grant and response delays, and checks
 * read data, error flags and trap addresses as results come out of WB.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

  import lsu_pkg::*;

  localparam int    MAX_OUT      = 2;
  localparam int    TIMEOUT      = 200;
  // Operand_b seen when the offset is not in use, moves the address by 17 words
  localparam addr_t STRAY_OFFSET = 32'h0000_0044;

  logic      clk;
  logic      rst_n;
  logic      lsu_en_i;
  logic      lsu_we_i;
  logic      lsu_sign_ext_i;
  logic      lsu_use_offset_i;
  lsu_size_t lsu_size_i;
  addr_t     operand_a_i;
  addr_t     operand_b_i;
  data_t     store_data_i;
  logic      ready_o;
  logic      busy_o;
  logic      wb_valid_o;
  logic      wb_err_o;
  data_t     wb_rdata_o;
  addr_t     wb_addr_o;
  logic      data_req_o;
  logic      data_gnt_i;
  logic      data_we_o;
  logic      data_rvalid_i;
  logic      data_err_i;
  addr_t     data_addr_o;
  be_t       data_be_o;
  data_t     data_wdata_o;
  data_t     data_rdata_i;

  // Bus memory and its in-order response queue
  data_t mem [256];
  data_t rsp_data_q[$];
  logic rsp_err_q[$];
  int rsp_due_q[$];
  int cyc;
  int gnt_wait;
  int grant_cnt;

  // Results still expected from WB, oldest first
  logic exp_we_q[$];
  data_t exp_data_q[$];
  logic exp_err_q[$];
  addr_t exp_addr_q[$];

  int errors;
  int checks;

  lsu_top #(.MAX_OUTSTANDING(MAX_OUT)) dut_i (.*);

  always #5 clk = ~clk;

  task automatic check_data(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timed out while waiting for %s at %0t", what, $time);
  endtask

  // Index of the lowest enabled byte lane
  function automatic byte_offset_t lowest_lane(input be_t be);
    byte_offset_t lane;
    lane = '0;
    for (int i = 3; i >= 0; i--)
      if (be[i])
        lane = byte_offset_t'(i);
    return lane;
  endfunction

  //////////////////////////////////////////////////////////////
  // Bus memory model, acts 2 ns after each rising edge
  //////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h4191_7fc8));
    forever
    begin
      @(posedge clk);
      #2;
      cyc++;
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
      data_err_i    = 1'b0;
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc)
      begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = rsp_data_q.pop_front();
        data_err_i    = rsp_err_q.pop_front();
        void'(rsp_due_q.pop_front());
      end
      data_gnt_i = 1'b0;
      if (data_req_o)
      begin
        if (gnt_wait < 0)
          gnt_wait = $urandom_range(2, 0);
        if (gnt_wait == 0)
        begin
          data_gnt_i = 1'b1;
          gnt_wait   = -1;
          grant_cnt++;
          // Byte address points at the first enabled lane
          check_addr("data_addr_o", data_addr_o, {data_addr_o[31:2], lowest_lane(data_be_o)});
          // Request is stable until the edge, so this transfer is accepted
          if (!data_addr_o[31] && data_we_o)
            for (int i = 0; i < 4; i++)
              if (data_be_o[i])
                mem[data_addr_o[9:2]][8*i +: 8] = data_wdata_o[8*i +: 8];
          rsp_data_q.push_back(data_addr_o[31] ? data_t'(0) : mem[data_addr_o[9:2]]);
          rsp_err_q.push_back(data_addr_o[31]);
          rsp_due_q.push_back(cyc + $urandom_range(3, 1));
          if (rsp_due_q.size() > MAX_OUT)
          begin
            errors++;
            $display("More than %0d bus transfers open at %0t", MAX_OUT, $time);
          end
        end
        else
          gnt_wait--;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // WB result monitor, samples at the falling edge
  //////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (wb_err_o && !wb_valid_o)
    begin
      errors++;
      $display("Bus error reported without a WB result at %0t", $time);
    end
    if (wb_valid_o)
    begin
      if (exp_we_q.size() == 0)
      begin
        errors++;
        $display("WB result with no access pending at %0t", $time);
      end
      else
      begin
        check_flag("wb_err_o", wb_err_o, exp_err_q[0]);
        if (exp_err_q[0])
          check_addr("wb_addr_o", wb_addr_o, exp_addr_q[0]);
        else if (!exp_we_q[0])
          check_data("wb_rdata_o", wb_rdata_o, exp_data_q[0]);
        void'(exp_we_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(exp_addr_q.pop_front());
      end
    end
  end

  // Wait for all pending WB results, inputs idle
  task automatic drain_results();
    int n;
    n = 0;
    while (exp_we_q.size() > 0)
    begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT)
      begin
        report_timeout("pending WB results");
        break;
      end
    end
  endtask

  // Drive one access, hold it until ready_o, then queue its expected result
  task automatic run_access(input lsu_size_t size, input logic sext, input logic we,
                            input addr_t base, input addr_t off, input data_t wdata,
                            input data_t exp_data, input logic exp_err);
    addr_t ea;
    logic  split;
    int    n;
    int    first_grant;
    ea    = base + off;
    split = (size == SIZE_WORD && ea[1:0] != 2'b00) ||
            (size == SIZE_HALF && ea[1:0] == 2'b11);
    first_grant    = grant_cnt;
    lsu_en_i       = 1'b1;
    lsu_we_i       = we;
    lsu_size_i     = size;
    lsu_sign_ext_i = sext;
    operand_a_i    = base;
    // Zero offset runs as a plain address, operand_b then has no effect
    lsu_use_offset_i = (off != '0);
    operand_b_i      = (off != '0) ? off : STRAY_OFFSET;
    store_data_i   = wdata;
    n = 0;
    @(negedge clk);
    while (!ready_o)
    begin
      n++;
      if (n > TIMEOUT)
      begin
        report_timeout("ready_o");
        break;
      end
      @(negedge clk);
    end
    // One transfer, two for an access across a word boundary
    check_count("bus transfers", grant_cnt - first_grant, split ? 2 : 1);
    exp_we_q.push_back(we);
    exp_data_q.push_back(exp_data);
    exp_err_q.push_back(exp_err);
    // Trap address is the last granted transfer, word-aligned for a second half
    exp_addr_q.push_back(split ? ((ea + 32'd4) & 32'hffff_fffc) : ea);
    @(posedge clk);
    #1;
    if (exp_err)
    begin
      // Keep later grants from moving the trap address
      lsu_en_i = 1'b0;
      drain_results();
    end
  endtask

  initial
  begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_size;
    logic [31:0] f_sext;
    logic [31:0] f_we;
    logic [31:0] f_base;
    logic [31:0] f_off;
    logic [31:0] f_wdata;
    logic [31:0] f_rdata;
    logic [31:0] f_err;
    clk = 1'b0;
    rst_n = 1'b0;
    lsu_en_i = 1'b0;
    lsu_we_i = 1'b0;
    lsu_size_i = SIZE_WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_use_offset_i = 1'b1;
    operand_a_i = '0;
    operand_b_i = '0;
    store_data_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    data_err_i = 1'b0;
    errors = 0;
    checks = 0;
    cyc = 0;
    gnt_wait = -1;
    grant_cnt = 0;
    for (int i = 0; i < 256; i++)
      mem[i] = 32'hd00d_0000 + i;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_flag("busy_o after reset", busy_o, 1'b0);
    check_flag("ready_o after reset", ready_o, 1'b0);
    check_flag("data_req_o after reset", data_req_o, 1'b0);
    check_flag("wb_valid_o after reset", wb_valid_o, 1'b0);
    check_flag("wb_err_o after reset", wb_err_o, 1'b0);
    check_addr("wb_addr_o after reset", wb_addr_o, '0);
    fd = $fopen("dv/lsu_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open dv/lsu_tests.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#" &&
            $sscanf(line, "%h %h %h %h %h %h %h %h", f_size, f_sext, f_we, f_base,
                    f_off, f_wdata, f_rdata, f_err) == 8)
          run_access(lsu_size_t'(f_size), f_sext[0], f_we[0], f_base, f_off, f_wdata,
                     f_rdata, f_err[0]);
      end
      $fclose(fd);
    end
    lsu_en_i = 1'b0;
    drain_results();
    // Unit must go idle once all responses are back
    n = 0;
    while (busy_o)
    begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT)
      begin
        report_timeout("busy_o to fall");
        break;
      end
    end
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: lsu_top.f
hw/lsu_pkg.sv
hw/lsu_req_gen.sv
hw/lsu_txn_ctrl.sv
hw/lsu_wb_stage.sv
hw/lsu_top.sv
dv/tb_lsu.sv

// File: run_sim.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_lsu -f lsu_top.f -o tb_lsu_sim \
  > sim.log 2>&1 &&
  ./obj_dir/tb_lsu_sim >> sim.log 2>&1 ||
  { echo "Build or simulation did not complete, see sim.log"; exit 1; }
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; } ||
  { echo "Simulation passed"; exit 0; }

// File: dv/lsu_tests.txt
# size(0 byte,1 half,2 word) sign_ext we base offset store_data exp_rdata exp_err
# all fields hex; exp_rdata is ignored for stores and for error accesses
2 0 1 00000100 00000000 a1b2c3d4 00000000 0
2 0 0 00000100 00000000 00000000 a1b2c3d4 0
0 1 0 00000100 00000003 00000000 ffffffa1 0
0 0 0 00000100 00000000 00000000 000000d4 0
1 1 0 00000100 00000002 00000000 ffffa1b2 0
1 0 0 00000100 00000000 00000000 0000c3d4 0
1 0 1 00000104 00000002 00008765 00000000 0
0 0 1 00000104 00000001 000000f0 00000000 0
2 0 0 00000104 00000000 00000000 8765f041 0
1 1 0 00000100 00000001 00000000 ffffb2c3 0
1 0 0 00000100 00000003 00000000 000041a1 0
2 0 0 00000100 00000002 00000000 f041a1b2 0
2 0 1 00000108 00000001 11223344 00000000 0
2 0 0 00000108 00000000 00000000 22334442 0
2 0 0 0000010c 00000000 00000000 d00d0011 0
2 0 0 00000108 00000003 00000000 0d001122 0
2 0 0 80000040 00000000 00000000 00000000 1
0 0 1 80000010 00000003 0000005a 00000000 1
2 0 0 00000108 00000000 00000000 22334442 0
1 1 0 00000104 00000002 00000000 ffff8765 0
0 0 0 00000101 ffffffff 00000000 000000d4 0
2 0 0 00000100 00000002 00000000 f041a1b2 0
1 0 0 00000100 00000003 00000000 000041a1 0
